//--- Makefile
# Verilator build and run for the rv64i core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_exec_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/exe_stage.sv
/* execute stage */

`timescale 1ns/1ps

module exe_stage #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_dec_req,
  output logic              o_dec_ack,
  input  rv_pkg::decoded_t  i_dec,
  output logic              o_exe_req,
  input  logic              i_exe_ack,
  output rv_pkg::executed_t o_exe
);

  rv_pkg::decoded_t  dec_q;
  rv_pkg::executed_t unit_out;
  logic              dec_hs;

  // one slot, which is free when empty or when the result leaves this cycle
  assign o_dec_ack = !o_exe_req || i_exe_ack;
  assign dec_hs    = i_dec_req && o_dec_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_exe_req <= 1'b0;
    end else if (dec_hs) begin
      o_exe_req <= 1'b1;
    end else if (i_exe_ack) begin
      o_exe_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hs) begin
      dec_q <= i_dec;
    end
  end

  exe_unit #(
    .XLEN (XLEN)
  ) u_exe_unit (
    .i_dec (dec_q),
    .o_exe (unit_out)
  );

  // an empty stage presents an all-zero record
  assign o_exe = o_exe_req ? unit_out : '0;

endmodule

//--- hw/exe_unit.sv
/* ALU and branch unit */

`timescale 1ns/1ps

module exe_unit #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  rv_pkg::decoded_t  i_dec,
  output rv_pkg::executed_t o_exe
);

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] t1;
  logic [XLEN-1:0] imm;
  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] next_pc;
  logic            take;
  logic            link;
  logic            jmp;

  assign pc    = i_dec.pc[XLEN-1:0];
  assign op1   = i_dec.op1[XLEN-1:0];
  assign op2   = i_dec.op2[XLEN-1:0];
  assign t1    = i_dec.t1[XLEN-1:0];
  assign imm   = i_dec.imm[XLEN-1:0];
  assign shamt = op2[SHW-1:0];

  always_comb begin
    case (i_dec.alu_op)
      rv_pkg::ALU_ADD:    alu_res = op1 + op2;
      rv_pkg::ALU_SUB:    alu_res = op1 - op2;
      rv_pkg::ALU_SLL:    alu_res = op1 << shamt;
      rv_pkg::ALU_SLT:    alu_res = XLEN'($signed(op1) < $signed(op2));
      rv_pkg::ALU_SLTU:   alu_res = XLEN'(op1 < op2);
      rv_pkg::ALU_XOR:    alu_res = op1 ^ op2;
      rv_pkg::ALU_SRL:    alu_res = op1 >> shamt;
      rv_pkg::ALU_SRA:    alu_res = $signed(op1) >>> shamt;
      rv_pkg::ALU_OR:     alu_res = op1 | op2;
      rv_pkg::ALU_AND:    alu_res = op1 & op2;
      rv_pkg::ALU_PASS_B: alu_res = op2;
      default:            alu_res = '0;
    endcase
  end

  always_comb begin
    case (i_dec.br_op)
      rv_pkg::BR_EQ:    take = (t1 == op2);
      rv_pkg::BR_NE:    take = (t1 != op2);
      rv_pkg::BR_LT:    take = ($signed(t1) < $signed(op2));
      rv_pkg::BR_GE:    take = ($signed(t1) >= $signed(op2));
      rv_pkg::BR_LTU:   take = (t1 < op2);
      rv_pkg::BR_GEU:   take = (t1 >= op2);
      rv_pkg::BR_JUMP:  take = 1'b1;
      rv_pkg::BR_JUMPR: take = 1'b1;
      default:          take = 1'b0;
    endcase
  end

  assign link     = (i_dec.br_op == rv_pkg::BR_JUMP) || (i_dec.br_op == rv_pkg::BR_JUMPR);
  assign pc_plus4 = pc + XLEN'(4);

  // JALR is based on rs1 and drops bit 0, everything else is pc relative
  assign target = (i_dec.br_op == rv_pkg::BR_JUMPR) ?
                  ((t1 + imm) & ~XLEN'(1)) : (pc + imm);

  assign next_pc = take ? target : pc_plus4;

  // the fetch side always assumes pc plus 4, so only a different pc is a jump
  assign jmp = (next_pc != pc_plus4);

  always_comb begin
    o_exe          = '0;
    o_exe.pc       = i_dec.pc;
    o_exe.inst     = i_dec.inst;
    o_exe.rd       = i_dec.rd;
    o_exe.rd_wen   = i_dec.rd_wen;
    o_exe.rd_wdata = link ? pc_plus4 : alu_res;
    o_exe.jmp      = jmp;
    o_exe.jmpaddr  = jmp ? next_pc : '0;
    o_exe.illegal  = i_dec.illegal;
  end

endmodule

//--- hw/id_stage.sv
/* decode stage with scoreboard */

`timescale 1ns/1ps

module id_stage #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_inst_req,
  output logic             o_inst_ack,
  input  logic [XLEN-1:0]  i_pc,
  input  logic [31:0]      i_inst,
  output logic [4:0]       o_ra1,
  output logic [4:0]       o_ra2,
  input  logic [XLEN-1:0]  i_rd1,
  input  logic [XLEN-1:0]  i_rd2,
  input  logic             i_clear_busy,
  input  logic [4:0]       i_clear_rd,
  output logic             o_dec_req,
  input  logic             i_dec_ack,
  output rv_pkg::decoded_t o_dec
);

  rv_pkg::opcode_e  opcode;
  logic [2:0]       funct3;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  logic [XLEN-1:0]  imm_i;
  logic [XLEN-1:0]  imm_u;
  logic [XLEN-1:0]  imm_j;
  logic [XLEN-1:0]  imm_b;
  logic             use_rs1;
  logic             use_rs2;
  logic [31:0]      busy;
  logic [31:0]      release_mask;
  logic [31:0]      pending;
  logic [31:0]      set_mask;
  logic             hazard;
  logic             inst_hs;
  rv_pkg::decoded_t dec_d;

  // OP and OP-IMM share the funct3 map, alt selects SUB or SRA
  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  alu_sel = rv_pkg::ALU_SLL;
      3'b010:  alu_sel = rv_pkg::ALU_SLT;
      3'b011:  alu_sel = rv_pkg::ALU_SLTU;
      3'b100:  alu_sel = rv_pkg::ALU_XOR;
      3'b101:  alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  alu_sel = rv_pkg::ALU_OR;
      default: alu_sel = rv_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = rv_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign rd     = i_inst[11:7];
  assign o_ra1  = rs1;
  assign o_ra2  = rs2;

  assign imm_i = $signed(i_inst[31:20]);
  assign imm_u = $signed({i_inst[31:12], 12'b0});
  assign imm_j = $signed({i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0});
  assign imm_b = $signed({i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0});

  always_comb begin
    dec_d         = '0;
    dec_d.pc      = i_pc;
    dec_d.inst    = i_inst;
    dec_d.alu_op  = rv_pkg::ALU_ADD;
    dec_d.br_op   = rv_pkg::BR_NONE;
    dec_d.op1     = i_rd1;
    dec_d.op2     = i_rd2;
    dec_d.t1      = i_rd1;
    dec_d.rd      = rd;
    use_rs1       = 1'b0;
    use_rs2       = 1'b0;
    case (opcode)
      rv_pkg::OPC_OP: begin
        dec_d.alu_op = alu_sel(funct3, i_inst[30]);
        dec_d.rd_wen = 1'b1;
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        dec_d.alu_op = alu_sel(funct3, (funct3 == 3'b101) && i_inst[30]);
        dec_d.op2    = imm_i;
        dec_d.rd_wen = 1'b1;
        use_rs1      = 1'b1;
      end
      rv_pkg::OPC_LUI: begin
        dec_d.alu_op = rv_pkg::ALU_PASS_B;
        dec_d.op2    = imm_u;
        dec_d.rd_wen = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        dec_d.op1    = i_pc;
        dec_d.op2    = imm_u;
        dec_d.rd_wen = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        dec_d.br_op  = rv_pkg::BR_JUMP;
        dec_d.op1    = i_pc;
        dec_d.op2    = imm_j;
        dec_d.imm    = imm_j;
        dec_d.rd_wen = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        dec_d.br_op  = rv_pkg::BR_JUMPR;
        dec_d.op2    = imm_i;
        dec_d.imm    = imm_i;
        dec_d.rd_wen = 1'b1;
        use_rs1      = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        dec_d.imm = imm_b;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        case (funct3)
          3'b000:  dec_d.br_op = rv_pkg::BR_EQ;
          3'b001:  dec_d.br_op = rv_pkg::BR_NE;
          3'b100:  dec_d.br_op = rv_pkg::BR_LT;
          3'b101:  dec_d.br_op = rv_pkg::BR_GE;
          3'b110:  dec_d.br_op = rv_pkg::BR_LTU;
          3'b111:  dec_d.br_op = rv_pkg::BR_GEU;
          default: dec_d.illegal = 1'b1;
        endcase
      end
      default: dec_d.illegal = 1'b1;
    endcase
    // writes to x0 are dropped here so they never touch the scoreboard
    dec_d.rd_wen = dec_d.rd_wen && (rd != 5'd0);
  end

  // a register released this cycle was written at the previous edge
  assign release_mask = i_clear_busy ? (32'd1 << i_clear_rd) : 32'd0;
  assign pending      = busy & ~release_mask;
  assign set_mask     = (inst_hs && dec_d.rd_wen) ? (32'd1 << rd) : 32'd0;

  // a pending write to rd also stalls, so an older release cannot clear a newer claim
  assign hazard = i_inst_req && ((use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2]) ||
                                 (dec_d.rd_wen && pending[rd]));

  assign o_inst_ack = (!o_dec_req || i_dec_ack) && !hazard;
  assign inst_hs    = i_inst_req && o_inst_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= '0;
      o_dec_req <= 1'b0;
    end else begin
      busy <= pending | set_mask;
      if (inst_hs) begin
        o_dec_req <= 1'b1;
      end else if (i_dec_ack) begin
        o_dec_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inst_hs) begin
      o_dec <= dec_d;
    end
  end

endmodule

//--- hw/regfile.sv
/* integer register file */

`timescale 1ns/1ps

module regfile #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      i_ra1,
  input  logic [4:0]      i_ra2,
  output logic [XLEN-1:0] o_rd1,
  output logic [XLEN-1:0] o_rd2,
  input  logic            i_we,
  input  logic [4:0]      i_wa,
  input  logic [XLEN-1:0] i_wd
);

  logic [XLEN-1:0] regs [32];

  // x0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_wa != 5'd0)) begin
      regs[i_wa] <= i_wd;
    end
  end

  assign o_rd1 = regs[i_ra1];
  assign o_rd2 = regs[i_ra2];

endmodule

//--- hw/rv_exec_top.sv
/* rv64i execute core top */

`timescale 1ns/1ps

module rv_exec_top #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_inst_req,
  output logic             o_inst_ack,
  input  logic [XLEN-1:0]  i_pc,
  input  logic [31:0]      i_inst,
  output logic             o_retire_valid,
  output rv_pkg::retire_t  o_retire
);

  logic [4:0]        ra1;
  logic [4:0]        ra2;
  logic [XLEN-1:0]   rd1;
  logic [XLEN-1:0]   rd2;
  logic              clear_busy;
  logic [4:0]        clear_rd;
  logic              dec_req;
  logic              dec_ack;
  rv_pkg::decoded_t  dec;
  logic              exe_req;
  logic              exe_ack;
  rv_pkg::executed_t exe;
  logic              wb_we;
  logic [4:0]        wb_rd;
  logic [XLEN-1:0]   wb_data;

  id_stage #(.XLEN(XLEN)) u_id_stage (
    .clk          (clk),
    .rst          (rst),
    .i_inst_req   (i_inst_req),
    .o_inst_ack   (o_inst_ack),
    .i_pc         (i_pc),
    .i_inst       (i_inst),
    .o_ra1        (ra1),
    .o_ra2        (ra2),
    .i_rd1        (rd1),
    .i_rd2        (rd2),
    .i_clear_busy (clear_busy),
    .i_clear_rd   (clear_rd),
    .o_dec_req    (dec_req),
    .i_dec_ack    (dec_ack),
    .o_dec        (dec)
  );

  exe_stage #(.XLEN(XLEN)) u_exe_stage (
    .clk       (clk),
    .rst       (rst),
    .i_dec_req (dec_req),
    .o_dec_ack (dec_ack),
    .i_dec     (dec),
    .o_exe_req (exe_req),
    .i_exe_ack (exe_ack),
    .o_exe     (exe)
  );

  wb_stage #(.XLEN(XLEN)) u_wb_stage (
    .clk            (clk),
    .rst            (rst),
    .i_exe_req      (exe_req),
    .o_exe_ack      (exe_ack),
    .i_exe          (exe),
    .o_wb_we        (wb_we),
    .o_wb_rd        (wb_rd),
    .o_wb_data      (wb_data),
    .o_clear_busy   (clear_busy),
    .o_clear_rd     (clear_rd),
    .o_retire_valid (o_retire_valid),
    .o_retire       (o_retire)
  );

  regfile #(.XLEN(XLEN)) u_regfile (
    .clk   (clk),
    .rst   (rst),
    .i_ra1 (ra1),
    .i_ra2 (ra2),
    .o_rd1 (rd1),
    .o_rd2 (rd2),
    .i_we  (wb_we),
    .i_wa  (wb_rd),
    .i_wd  (wb_data)
  );

endmodule

//--- hw/rv_pkg.sv
/* rv64i core shared types */

package rv_pkg;

  // record fields are sized for the widest core, narrower cores use the low bits
  localparam int XLEN = 64;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE,
    BR_LTU, BR_GEU, BR_JUMP, BR_JUMPR
  } br_op_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    alu_op_e         alu_op;
    br_op_e          br_op;
    // op1 is rs1, or the pc for AUIPC and JAL
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    // t1 is the rs1 base used by branches and JALR
    logic [XLEN-1:0] t1;
    logic [XLEN-1:0] imm;
    logic [4:0]      rd;
    logic            rd_wen;
    logic            illegal;
  } decoded_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [XLEN-1:0] rd_wdata;
    logic            jmp;
    logic [XLEN-1:0] jmpaddr;
    logic            illegal;
  } executed_t;

  typedef executed_t retire_t;

endpackage

//--- hw/wb_stage.sv
/* result stage */

`timescale 1ns/1ps

module wb_stage #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_exe_req,
  output logic              o_exe_ack,
  input  rv_pkg::executed_t i_exe,
  output logic              o_wb_we,
  output logic [4:0]        o_wb_rd,
  output logic [XLEN-1:0]   o_wb_data,
  output logic              o_clear_busy,
  output logic [4:0]        o_clear_rd,
  output logic              o_retire_valid,
  output rv_pkg::retire_t   o_retire
);

  logic exe_hs;

  // nothing downstream can stall, so every result is taken at once
  assign o_exe_ack = 1'b1;
  assign exe_hs    = i_exe_req && o_exe_ack;

  assign o_wb_we   = exe_hs && i_exe.rd_wen && !i_exe.illegal && (i_exe.rd != 5'd0);
  assign o_wb_rd   = i_exe.rd;
  assign o_wb_data = i_exe.rd_wdata[XLEN-1:0];

  // the release follows the write by one cycle so decode reads the new value
  always_ff @(posedge clk) begin
    if (rst) begin
      o_retire_valid <= 1'b0;
      o_clear_busy   <= 1'b0;
    end else begin
      o_retire_valid <= exe_hs;
      o_clear_busy   <= o_wb_we;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_hs) begin
      o_retire   <= i_exe;
      o_clear_rd <= i_exe.rd;
    end
  end

endmodule

//--- tb/tb_rv_exec_top.sv
/* rv64i core directed testbench */

`timescale 1ns/1ps

module tb_rv_exec_top;

  localparam int XLEN        = 64;
  localparam int ACK_LIMIT   = 40;
  localparam int DRAIN_LIMIT = 60;

  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] BRANCH = 7'b1100011;

  logic            clk;
  logic            rst;
  logic            i_inst_req;
  logic            o_inst_ack;
  logic [XLEN-1:0] i_pc;
  logic [31:0]     i_inst;
  logic            o_retire_valid;
  rv_pkg::retire_t o_retire;

  logic [63:0]     shadow [32];
  rv_pkg::retire_t exp_q [$];
  logic [63:0]     cur_pc;
  logic [31:0]     rng_state;
  string           test_name;
  int              errors;
  int              checks;

  rv_exec_top #(
    .XLEN (XLEN)
  ) i_rv_exec_top (
    .clk            (clk),
    .rst            (rst),
    .i_inst_req     (i_inst_req),
    .o_inst_ack     (o_inst_ack),
    .i_pc           (i_pc),
    .i_inst         (i_inst),
    .o_retire_valid (o_retire_valid),
    .o_retire       (o_retire)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
  endfunction

  // results follow the base ISA, where a 64-bit core shifts by the low 6 bits
  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'b000: begin
        if (alt) return a - b;
        else return a + b;
      end
      3'b001:  return a << b[5:0];
      3'b010:  return {63'd0, $signed(a) < $signed(b)};
      3'b011:  return {63'd0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[5:0];
        else return a >> b[5:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [63:0] a,
                                      input logic [63:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic finish_run();
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic abort(input string why);
    errors++;
    $display("%s: %s", test_name, why);
    finish_run();
  endtask

  task automatic check_field(input string field, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, field, exp, act);
    end
  endtask

  // builds the expected retire record and updates the shadow registers in program order
  task automatic predict(input logic [63:0] pc, input logic [31:0] inst);
    rv_pkg::retire_t e;
    logic [63:0]     a;
    logic [63:0]     b;
    logic [63:0]     imm_i;
    logic [63:0]     imm_u;
    logic [63:0]     imm_j;
    logic [63:0]     imm_b;
    logic [63:0]     res;
    logic [63:0]     target;
    logic [2:0]      f3;
    logic            writes;
    logic            taken;
    e      = '0;
    a      = shadow[inst[19:15]];
    b      = shadow[inst[24:20]];
    f3     = inst[14:12];
    imm_i  = {{52{inst[31]}}, inst[31:20]};
    imm_u  = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j  = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_b  = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    writes = 1'b1;
    taken  = 1'b0;
    target = '0;
    res    = '0;
    case (inst[6:0])
      OP:     res = alu_ref(f3, inst[30], a, b);
      OP_IMM: res = alu_ref(f3, (f3 == 3'b101) && inst[30], a, imm_i);
      LUI:    res = imm_u;
      AUIPC:  res = pc + imm_u;
      JAL: begin
        res    = pc + 64'd4;
        taken  = 1'b1;
        target = pc + imm_j;
      end
      JALR: begin
        res    = pc + 64'd4;
        taken  = 1'b1;
        target = (a + imm_i) & ~64'd1;
      end
      BRANCH: begin
        writes = 1'b0;
        taken  = branch_ref(f3, a, b);
        target = pc + imm_b;
      end
      default: begin
        writes    = 1'b0;
        e.illegal = 1'b1;
      end
    endcase
    e.pc       = pc;
    e.inst     = inst;
    e.rd       = inst[11:7];
    e.rd_wen   = writes && (inst[11:7] != 5'd0);
    e.rd_wdata = res;
    e.jmp      = taken && (target != pc + 64'd4);
    e.jmpaddr  = e.jmp ? target : 64'd0;
    if (e.rd_wen) begin
      shadow[inst[11:7]] = res;
    end
    exp_q.push_back(e);
  endtask

  // the task starts on a rising edge and returns on the handshake edge with req still high
  task automatic issue(input logic [31:0] inst);
    int n;
    predict(cur_pc, inst);
    i_inst_req <= 1'b1;
    i_pc       <= cur_pc;
    i_inst     <= inst;
    cur_pc = cur_pc + 64'd4;
    n = 0;
    @(negedge clk);
    while (!o_inst_ack) begin
      if (n >= ACK_LIMIT) begin
        abort("o_inst_ack never came for the pending instruction");
      end
      n++;
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic idle();
    i_inst_req <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n >= DRAIN_LIMIT) begin
        abort("o_retire_valid never came for an outstanding instruction");
      end
      n++;
      @(posedge clk);
    end
  endtask

  task automatic run_one(input logic [31:0] inst);
    issue(inst);
    idle();
    drain();
  endtask

  // x31 serves as scratch while the shift by 32 fills the upper word
  task automatic load_rand(input logic [4:0] rd);
    logic [31:0] r;
    r = next_rand();
    run_one(enc_u(LUI, rd, r[31:12]));
    run_one(enc_i(OP_IMM, rd, 3'b000, rd, r[11:0]));
    run_one(enc_i(OP_IMM, rd, 3'b001, rd, 12'd32));
    r = next_rand();
    run_one(enc_u(LUI, 5'd31, r[31:12]));
    run_one(enc_i(OP_IMM, 5'd31, 3'b000, 5'd31, r[11:0]));
    run_one(enc_r(7'd0, 5'd31, rd, 3'b100, rd));
  endtask

  always @(negedge clk) begin : retire_monitor
    rv_pkg::retire_t e;
    if (!rst && o_retire_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: a result retired with no instruction outstanding", test_name);
      end else begin
        e = exp_q.pop_front();
        check_field("pc", e.pc, o_retire.pc);
        check_field("inst", 64'(e.inst), 64'(o_retire.inst));
        check_field("rd_wen", 64'(e.rd_wen), 64'(o_retire.rd_wen));
        check_field("illegal", 64'(e.illegal), 64'(o_retire.illegal));
        check_field("jmp", 64'(e.jmp), 64'(o_retire.jmp));
        check_field("jmpaddr", e.jmpaddr, o_retire.jmpaddr);
        if (e.rd_wen) begin
          check_field("rd", 64'(e.rd), 64'(o_retire.rd));
          check_field("rd_wdata", e.rd_wdata, o_retire.rd_wdata);
        end
      end
    end
  end

  task automatic reset_test();
    test_name = "reset_test";
    repeat (4) begin
      @(negedge clk);
      check_field("retire_valid", 64'd0, 64'(o_retire_valid));
      check_field("inst_ack", 64'd1, 64'(o_inst_ack));
    end
    @(posedge clk);
    run_one(enc_i(OP_IMM, 5'd0, 3'b000, 5'd0, 12'd5));
  endtask

  task automatic imm_test();
    logic [31:0] r;
    logic [4:0]  rd;
    test_name = "imm_test";
    for (int i = 0; i < 8; i++) begin
      r  = next_rand();
      rd = r[26:22] | 5'd1;
      run_one(enc_u(LUI, rd, r[31:12]));
      run_one(enc_i(OP_IMM, rd, 3'b000, rd, r[11:0]));
      r = next_rand();
      run_one(enc_i(OP_IMM, r[4:0], 3'b000, 5'd0, r[31:20]));
      run_one(enc_u(AUIPC, r[9:5], r[31:12]));
    end
  endtask

  task automatic alu_test();
    logic [2:0] f3;
    logic       alt;
    test_name = "alu_test";
    for (int round = 0; round < 4; round++) begin
      load_rand(5'd1);
      load_rand(5'd2);
      // the eight funct3 codes come first and SUB and SRA follow
      for (int k = 0; k < 10; k++) begin
        f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
        alt = (k >= 8);
        run_one(enc_r({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd3));
      end
    end
    load_rand(5'd1);
    run_one(enc_i(OP_IMM, 5'd4, 3'b001, 5'd1, {6'b000000, 6'd45}));
    run_one(enc_i(OP_IMM, 5'd4, 3'b101, 5'd1, {6'b000000, 6'd40}));
    run_one(enc_i(OP_IMM, 5'd4, 3'b101, 5'd1, {6'b010000, 6'd63}));
    run_one(enc_i(OP_IMM, 5'd2, 3'b000, 5'd0, 12'd50));
    run_one(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));
    run_one(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));
    run_one(enc_i(OP_IMM, 5'd1, 3'b000, 5'd0, 12'hffd));
    run_one(enc_i(OP_IMM, 5'd2, 3'b000, 5'd0, 12'd5));
    run_one(enc_r(7'd0, 5'd2, 5'd1, 3'b010, 5'd3));
    run_one(enc_r(7'd0, 5'd2, 5'd1, 3'b011, 5'd3));
    run_one(enc_i(OP_IMM, 5'd3, 3'b010, 5'd1, 12'd5));
    run_one(enc_i(OP_IMM, 5'd3, 3'b011, 5'd2, 12'hfff));
  endtask

  task automatic branch_test();
    logic [11:0] a;
    logic [11:0] b;
    logic [2:0]  f3;
    test_name = "branch_test";
    // operand pairs (-5, 7), (7, 7) and (7, -5) give every branch both outcomes
    for (int p = 0; p < 3; p++) begin
      a = (p == 0) ? 12'hffb : 12'd7;
      b = (p == 2) ? 12'hffb : 12'd7;
      run_one(enc_i(OP_IMM, 5'd1, 3'b000, 5'd0, a));
      run_one(enc_i(OP_IMM, 5'd2, 3'b000, 5'd0, b));
      for (int k = 0; k < 6; k++) begin
        f3 = (k < 2) ? 3'(k) : 3'(k + 2);
        run_one(enc_b(f3, 5'd1, 5'd2, 13'h1ff0));
        run_one(enc_b(f3, 5'd1, 5'd2, 13'd4));
      end
    end
    run_one(enc_j(5'd10, 21'h000100));
    run_one(enc_j(5'd10, 21'd4));
    run_one(enc_j(5'd0, 21'h1ffff8));
    run_one(enc_i(OP_IMM, 5'd12, 3'b000, 5'd0, 12'h100));
    run_one(enc_i(JALR, 5'd11, 3'b000, 5'd12, 12'd7));
    run_one(enc_i(JALR, 5'd11, 3'b000, 5'd12, 12'hffd));
  endtask

  task automatic hazard_test();
    logic [31:0] r;
    test_name = "hazard_test";
    @(posedge clk);
    for (int round = 0; round < 3; round++) begin
      r = next_rand();
      issue(enc_i(OP_IMM, 5'd5, 3'b000, 5'd0, r[11:0]));
      issue(enc_i(OP_IMM, 5'd5, 3'b000, 5'd5, r[23:12]));
      issue(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
      issue(enc_i(OP_IMM, 5'd20, 3'b000, 5'd0, r[31:20]));
      issue(enc_r(7'h20, 5'd5, 5'd6, 3'b000, 5'd7));
      issue(enc_i(OP_IMM, 5'd21, 3'b000, 5'd0, r[19:8]));
      issue(enc_r(7'h00, 5'd7, 5'd6, 3'b100, 5'd8));
      issue(enc_r(7'h00, 5'd5, 5'd8, 3'b001, 5'd9));
      idle();
      drain();
    end
    // independent writes flow through without a stall
    for (int k = 22; k < 26; k++) begin
      issue(enc_i(OP_IMM, 5'(k), 3'b000, 5'd0, 12'(k * 3)));
    end
    issue(enc_r(7'h00, 5'd23, 5'd22, 3'b000, 5'd26));
    idle();
    drain();
  endtask

  task automatic illegal_test();
    test_name = "illegal_test";
    run_one(enc_i(OP_IMM, 5'd5, 3'b000, 5'd0, 12'h123));
    run_one(enc_i(7'b0000011, 5'd5, 3'b011, 5'd0, 12'd0));
    run_one(32'hffff_ffff);
    run_one(enc_r(7'h00, 5'd0, 5'd5, 3'b000, 5'd9));
    run_one(enc_r(7'h00, 5'd0, 5'd31, 3'b000, 5'd10));
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    i_inst_req = 1'b0;
    i_pc       = '0;
    i_inst     = '0;
    rng_state  = 32'hc529;
    cur_pc     = 64'h1000;
    errors     = 0;
    checks     = 0;
    test_name  = "reset";
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    reset_test();
    imm_test();
    alu_test();
    branch_test();
    hazard_test();
    illegal_test();
    finish_run();
  end

endmodule

//--- vlog.f
hw/rv_pkg.sv
hw/regfile.sv
hw/id_stage.sv
hw/exe_unit.sv
hw/exe_stage.sv
hw/wb_stage.sv
hw/rv_exec_top.sv
tb/tb_rv_exec_top.sv
